//--- dv/instrCases.txt
# instr(hex) expectWrite expectReg expectData(hex) tag, one instruction per line
# Registers start at zero after reset; each line sees the results of all lines above it.
C112 1 1 0012 lbiPos
9134 1 1 1234 slbiLow
C280 1 2 FF80 lbiNeg
92FF 1 2 80FF slbiNeg
C37F 1 3 007F lbiMax
93FF 1 3 7FFF slbiMax
C401 1 4 0001 lbiOne
41BF 1 5 1233 addiNeg
41AF 1 5 1243 addiPos
4CC3 1 6 0002 subiPos
49D0 1 6 EDBC subiNeg
51FF 1 7 122B xoriZext
5AFF 1 7 80E0 andniZext
D954 1 5 9333 addReg
DC39 1 6 1233 subReg
D97E 1 7 6DCB xorReg
DA3F 1 7 80CB andnReg
A1A0 1 5 1234 roli0
A2A1 1 5 01FF roli1
A9A8 1 5 3400 slli8
AACF 1 6 8000 slli15
B1C8 1 6 3412 rori8
B2CF 1 6 01FF rori15
BAE1 1 7 407F srli1
BAEF 1 7 0001 srli15
D194 1 5 2468 rolReg1
D279 1 6 8000 sllReg15
D11E 1 7 1234 rorReg0
C408 1 4 0008 lbiShamt
D29F 1 7 0080 srlReg8
E134 1 5 0001 seqEqual
E174 1 5 0000 seqDiff
EA38 1 6 0001 sltNegPos
E958 1 6 0000 sltPosNeg
F13C 1 7 0001 sleEqual
F35C 1 7 0000 slePosNeg
FA54 1 5 0001 scoCarry
F974 1 5 0000 scoNoCarry
C918 1 6 2C48 btrValue
0800 0 0 0000 nop
8120 0 0 0000 store
6104 0 0 0000 branch
46A1 1 5 2C49 depAdd1
45A1 1 5 2C4A depAdd2
DEB5 1 5 0002 depSub
0000 0 0 0000 halt
C155 0 0 0000 afterHalt1
45A1 0 0 0000 afterHalt2

//--- verilog.f
src/isaPkg.sv
src/control.sv
src/operandFetch.sv
src/alu.sv
src/decodeExecute.sv
dv/resultChecker.sv
dv/tbDecodeExecute.sv

//--- dv/tbDecodeExecute.sv
// Testbench top; plays the instruction cases file through the decode and execute slice.
`timescale 1ns/1ps

module tbDecodeExecute;

   localparam int caseTimeout = 50;
   localparam int runTimeout  = 2000;
   localparam int randomSeed  = 50247;

   logic         clk;
   logic         reset;
   logic         instrValid;
   logic [15:0]  instr;
   logic         wbValid;
   logic [2:0]   wbReg;
   logic [15:0]  wbData;
   logic         halted;
   logic         expectWrite;
   logic [2:0]   expectReg;
   logic [15:0]  expectData;
   logic [127:0] caseTag;
   int           passCount;
   int           failCount;
   int           checkedCount;
   int           issued;
   logic         timedOut;
   logic         fileError;

   decodeExecute #(
      .numRegs (8)
   ) decodeExecute_inst (
      .clk        (clk),
      .reset      (reset),
      .instrValid (instrValid),
      .instr      (instr),
      .wbValid    (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .halted     (halted)
   );

   resultChecker resultChecker_inst (
      .clk          (clk),
      .reset        (reset),
      .instrValid   (instrValid),
      .instr        (instr),
      .expectWrite  (expectWrite),
      .expectReg    (expectReg),
      .expectData   (expectData),
      .caseTag      (caseTag),
      .wbValid      (wbValid),
      .wbReg        (wbReg),
      .wbData       (wbData),
      .halted       (halted),
      .passCount    (passCount),
      .failCount    (failCount),
      .checkedCount (checkedCount)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin : runWatchdog
      int cycles;
      cycles = 0;
      while (cycles < runTimeout) begin
         @(posedge clk);
         cycles++;
      end
      $display("Run did not finish within %0d cycles", runTimeout);
      $display("STATUS: FAIL");
      $finish;
   end

   // One-cycle strobe, driven 1 ns after the edge.
   task automatic driveInstr(input logic [15:0] word, input logic wr, input logic [2:0] rg,
                             input logic [15:0] data, input logic [127:0] tag);
      instr       = word;
      expectWrite = wr;
      expectReg   = rg;
      expectData  = data;
      caseTag     = tag;
      instrValid  = 1'b1;
      @(posedge clk);
      #1;
      instrValid  = 1'b0;
      issued++;
   endtask

   task automatic waitIdle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic waitChecked(input int target);
      int waited;
      waited = 0;
      while (checkedCount < target && waited < caseTimeout) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (checkedCount < target) begin
         $display("Case %0d got no result within %0d cycles", target, caseTimeout);
         timedOut = 1'b1;
      end
   endtask

   initial begin : stimulus
      int               fd;
      int               fields;
      int               skipped;
      logic [15:0]      word;
      logic [3:0]       fileWrite;
      logic [3:0]       fileReg;
      logic [15:0]      data;
      logic [127:0]     tag;
      logic [8*128-1:0] lineBuf;

      instrValid  = 1'b0;
      instr       = '0;
      expectWrite = 1'b0;
      expectReg   = '0;
      expectData  = '0;
      caseTag     = '0;
      issued      = 0;
      timedOut    = 1'b0;
      fileError   = 1'b0;
      reset       = 1'b1;
      void'($urandom(randomSeed));
      fd = $fopen("dv/instrCases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the cases file dv/instrCases.txt");
         fileError = 1'b1;
      end
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;
      while (fd != 0 && !timedOut) begin
         fields = $fscanf(fd, "%h %h %h %h %s\n", word, fileWrite, fileReg, data, tag);
         if (fields == 5) begin
            driveInstr(word, fileWrite[0], fileReg[2:0], data, tag);
            waitChecked(issued - 1);   // Lets dependent instructions run back to back.
            waitIdle($urandom % 4);
         end else if (fields == 0) begin
            skipped = $fgets(lineBuf, fd);   // Comment line.
            if (skipped == 0) begin
               break;
            end
         end else if (fields > 0) begin
            $display("Malformed line after case %0d in the cases file", issued);
            fileError = 1'b1;
            break;
         end else begin
            break;
         end
      end
      if (!timedOut) begin
         waitChecked(issued);
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      $display("Cases issued: %0d, checked: %0d, passed: %0d, failed: %0d",
               issued, checkedCount, passCount, failCount);
      if (timedOut || fileError || issued == 0 || failCount != 0 || checkedCount != issued) begin
         $display("STATUS: FAIL");
      end else begin
         $display("STATUS: PASS");
      end
      $finish;
   end

endmodule

//--- dv/resultChecker.sv
// Watches write-back and halted, and compares each strobed instruction with its expectation.
`timescale 1ns/1ps

module resultChecker (
   input  logic         clk,
   input  logic         reset,
   input  logic         instrValid,
   input  logic [15:0]  instr,
   input  logic         expectWrite,
   input  logic [2:0]   expectReg,
   input  logic [15:0]  expectData,
   input  logic [127:0] caseTag,
   input  logic         wbValid,
   input  logic [2:0]   wbReg,
   input  logic [15:0]  wbData,
   input  logic         halted,
   output int           passCount,
   output int           failCount,
   output int           checkedCount
);

   localparam logic [4:0] haltOpcode = 5'b00000;

   // Expectation of the instruction in flight, due one edge after its strobe.
   logic         pendValid;
   logic         pendWrite;
   logic [2:0]   pendReg;
   logic [15:0]  pendData;
   logic [127:0] pendTag;
   logic         pendHalt;
   logic         expectHalted;
   int           caseErrors;

   initial begin
      passCount    = 0;
      failCount    = 0;
      checkedCount = 0;
      pendValid    = 1'b0;
      pendHalt     = 1'b0;
      expectHalted = 1'b0;
   end

   // Outputs are settled at the falling edge.
   always @(negedge clk) begin
      if (reset !== 1'b0) begin
         pendValid    = 1'b0;
         pendHalt     = 1'b0;
         expectHalted = 1'b0;
      end else begin
         caseErrors = 0;
         if (pendHalt) begin
            expectHalted = 1'b1;
         end
         if (halted !== expectHalted) begin
            $display("CHECK FAILED at %0t ns: halted = %0b, expected %0b",
                     $time, halted, expectHalted);
            caseErrors++;
         end
         if (pendValid) begin
            if (pendWrite && wbValid !== 1'b1) begin
               $display("At %0t ns case %0s expected a write-back pulse but none came",
                        $time, pendTag);
               caseErrors++;
            end else if (!pendWrite && wbValid !== 1'b0) begin
               $display("At %0t ns case %0s gave a write-back pulse but should write nothing",
                        $time, pendTag);
               caseErrors++;
            end else if (pendWrite) begin
               if (wbReg !== pendReg) begin
                  $display("CHECK FAILED at %0t ns: wbReg = %0d, expected %0d",
                           $time, wbReg, pendReg);
                  caseErrors++;
               end
               if (wbData !== pendData) begin
                  $display("CHECK FAILED at %0t ns: wbData = %h, expected %h",
                           $time, wbData, pendData);
                  caseErrors++;
               end
            end
            checkedCount++;
            if (caseErrors == 0) begin
               passCount++;
               $display("case %0d %0s: ok", checkedCount, pendTag);
            end else begin
               failCount++;
               $display("case %0d %0s: failed", checkedCount, pendTag);
            end
         end else if (wbValid !== 1'b0) begin
            $display("At %0t ns a write-back pulse came with no instruction strobed", $time);
            failCount++;
         end else if (caseErrors != 0) begin
            failCount++;
         end
         pendValid = instrValid;
         pendHalt  = 1'b0;
         if (instrValid) begin
            pendWrite = expectWrite;
            pendReg   = expectReg;
            pendData  = expectData;
            pendTag   = caseTag;
            pendHalt  = (instr[15:11] == haltOpcode);
         end
      end
   end

endmodule

//--- src/decodeExecute.sv
// Top of the decode and execute slice; instr in with a strobe, one-cycle write-back pulse out.
`timescale 1ns/1ps

module decodeExecute #(
   parameter int numRegs = 8
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           instrValid,
   input  logic [15:0]                    instr,
   output logic                           wbValid,
   output logic [isaPkg::regIdxWidth-1:0] wbReg,
   output logic [isaPkg::dataWidth-1:0]   wbData,
   output logic                           halted
);
   import isaPkg::*;

   opcodeT                 opcode;
   aluOpT                  aluOp;
   logic [1:0]             regSrc;
   logic [1:0]             bSel;
   logic [1:0]             regDst;
   logic                   regWrite;
   logic                   zeroExt;
   logic                   shift;
   logic                   subtract;
   logic                   invA;
   logic                   invB;
   logic                   slbi;
   logic                   btr;
   logic                   halt;
   logic [dataWidth-1:0]   opA;
   logic [dataWidth-1:0]   opB;
   logic [dataWidth-1:0]   rawB;
   logic [dataWidth-1:0]   immExt;
   logic [dataWidth-1:0]   aluResult;
   logic                   writeEn;
   logic [regIdxWidth-1:0] writeIdx;
   logic [dataWidth-1:0]   writeData;

   assign opcode = opcodeT'(instr[15:11]);

   control control_inst (
      .opcode   (opcode),
      .aluOp    (aluOp),
      .regSrc   (regSrc),
      .bSel     (bSel),
      .regDst   (regDst),
      .regWrite (regWrite),
      .zeroExt  (zeroExt),
      .shift    (shift),
      .subtract (subtract),
      .invA     (invA),
      .invB     (invB),
      .slbi     (slbi),
      .btr      (btr),
      .halt     (halt)
   );

   operandFetch #(
      .numRegs (numRegs)
   ) operandFetch_inst (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .bSel      (bSel),
      .zeroExt   (zeroExt),
      .writeEn   (writeEn),
      .writeIdx  (writeIdx),
      .writeData (writeData),
      .opA       (opA),
      .opB       (opB),
      .rawB      (rawB),
      .immExt    (immExt)
   );

   alu alu_inst (
      .aluOp    (aluOp),
      .func     (instr[1:0]),
      .opA      (opA),
      .opB      (opB),
      .rawB     (rawB),
      .invA     (invA),
      .invB     (invB),
      .subtract (subtract),
      .shift    (shift),
      .slbi     (slbi),
      .btr      (btr),
      .result   (aluResult)
   );

   always_comb begin
      case (regDst)
         dstRd:  writeIdx = instr[4:2];
         dstIRd: writeIdx = instr[7:5];
         dstRs:  writeIdx = instr[10:8];
         dstR7:  writeIdx = {regIdxWidth{1'b1}};
      endcase
   end

   assign writeData = (regSrc == srcImm) ? immExt : aluResult;
   assign writeEn   = instrValid && !halted && regWrite;   // Strobes after HALT are dropped.

   always_ff @(posedge clk) begin
      if (reset) begin
         wbValid <= 1'b0;
         halted  <= 1'b0;
      end else begin
         wbValid <= writeEn;
         if (instrValid && halt) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (writeEn) begin
         wbReg  <= writeIdx;
         wbData <= writeData;
      end
   end

endmodule

//--- src/alu.sv
// ALU for the slice; add/sub, logic, barrel rotate and shift, SLBI, set-on-compare and BTR.
`timescale 1ns/1ps

module alu (
   input  isaPkg::aluOpT                aluOp,
   input  logic [1:0]                   func,
   input  logic [isaPkg::dataWidth-1:0] opA,
   input  logic [isaPkg::dataWidth-1:0] opB,
   input  logic [isaPkg::dataWidth-1:0] rawB,
   input  logic                         invA,
   input  logic                         invB,
   input  logic                         subtract,
   input  logic                         shift,
   input  logic                         slbi,
   input  logic                         btr,
   output logic [isaPkg::dataWidth-1:0] result
);
   import isaPkg::*;

   localparam int shAmtWidth = $clog2(dataWidth);

   aluOpT                  opSel;
   logic                   effInvA;
   logic                   effInvB;
   logic                   carryIn;
   logic [dataWidth-1:0]   bSrc;
   logic [dataWidth-1:0]   aIn;
   logic [dataWidth-1:0]   bIn;
   logic [dataWidth:0]     sum;
   logic [shAmtWidth-1:0]  shAmt;
   logic [2*dataWidth-1:0] rotLeft;
   logic [2*dataWidth-1:0] rotRight;
   logic [dataWidth-1:0]   reversed;
   logic                   overflow;
   logic                   less;
   logic                   cmpBit;

   // R-format ops take their kind from func.
   always_comb begin
      opSel   = aluOp;
      effInvA = invA;
      effInvB = invB;
      carryIn = subtract;
      if (aluOp == aluRegArith) begin
         case (func)
            2'b00: opSel = aluAdd;
            2'b01: begin
               opSel   = aluAdd;   // SUB is Rt - Rs.
               effInvA = 1'b1;
               carryIn = 1'b1;
            end
            2'b10: opSel = aluXor;
            default: begin
               opSel   = aluAndn;
               effInvB = 1'b1;
            end
         endcase
      end else if (aluOp == aluRegShift) begin
         case (func)
            2'b00:   opSel = aluRol;
            2'b01:   opSel = aluSll;
            2'b10:   opSel = aluRor;
            default: opSel = aluSrl;
         endcase
      end
   end

   assign bSrc = shift ? rawB : opB;   // Compares always use register B.
   assign aIn  = slbi    ? (opA << (dataWidth / 2)) :
                 effInvA ? ~opA : opA;
   assign bIn  = effInvB ? ~bSrc : bSrc;
   assign sum  = {1'b0, aIn} + {1'b0, bIn} + carryIn;

   assign shAmt    = opB[shAmtWidth-1:0];
   assign rotLeft  = {opA, opA} << shAmt;
   assign rotRight = {opA, opA} >> shAmt;

   always_comb begin
      for (int i = 0; i < dataWidth; i++) begin
         reversed[i] = opA[dataWidth-1-i];
      end
   end

   // Signed flags of the compare adder.
   assign overflow = (aIn[dataWidth-1] == bIn[dataWidth-1]) &&
                     (sum[dataWidth-1] != aIn[dataWidth-1]);
   assign less     = sum[dataWidth-1] ^ overflow;
   assign cmpBit   = (aluOp == aluXor) ? (opA == rawB) :   // SEQ.
                     !subtract         ? sum[dataWidth] :  // SCO.
                     invA              ? ~less : less;

   always_comb begin
      if (btr) begin
         result = reversed;
      end else if (shift) begin
         result = {{(dataWidth-1){1'b0}}, cmpBit};
      end else begin
         case (opSel)
            aluRol:  result = rotLeft[2*dataWidth-1:dataWidth];
            aluSll:  result = opA << shAmt;
            aluRor:  result = rotRight[dataWidth-1:0];
            aluSrl:  result = opA >> shAmt;
            aluSlbi: result = aIn | bIn;
            aluXor:  result = aIn ^ bIn;
            aluAndn: result = aIn & bIn;
            aluPass: result = bIn;
            default: result = sum[dataWidth-1:0];
         endcase
      end
   end

endmodule

//--- src/operandFetch.sv
// Register file with two asynchronous read ports and one write port, plus immediate extension.
`timescale 1ns/1ps

module operandFetch #(
   parameter int numRegs = 8
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [15:0]                    instr,
   input  logic [1:0]                     bSel,
   input  logic                           zeroExt,
   input  logic                           writeEn,
   input  logic [isaPkg::regIdxWidth-1:0] writeIdx,
   input  logic [isaPkg::dataWidth-1:0]   writeData,
   output logic [isaPkg::dataWidth-1:0]   opA,
   output logic [isaPkg::dataWidth-1:0]   opB,
   output logic [isaPkg::dataWidth-1:0]   rawB,
   output logic [isaPkg::dataWidth-1:0]   immExt
);
   import isaPkg::*;

   logic [dataWidth-1:0]   regs [numRegs];
   logic [regIdxWidth-1:0] rsIdx;
   logic [regIdxWidth-1:0] rtIdx;
   logic [4:0]             imm5;
   logic [7:0]             imm8;
   logic [dataWidth-1:0]   imm5Ext;

   assign rsIdx = instr[10:8];
   assign rtIdx = instr[7:5];
   assign imm5  = instr[4:0];
   assign imm8  = instr[7:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && (writeIdx < numRegs)) begin
         regs[writeIdx] <= writeData;
      end
   end

   // Indices past the end of a small register file read as zero.
   assign opA  = (rsIdx < numRegs) ? regs[rsIdx] : '0;
   assign rawB = (rtIdx < numRegs) ? regs[rtIdx] : '0;

   assign imm5Ext = zeroExt ? {{(dataWidth-5){1'b0}}, imm5} :
                              {{(dataWidth-5){imm5[4]}}, imm5};
   assign immExt  = zeroExt ? {{(dataWidth-8){1'b0}}, imm8} :
                              {{(dataWidth-8){imm8[7]}}, imm8};

   always_comb begin
      case (bSel)
         bSelImm5: opB = imm5Ext;
         bSelImm8: opB = immExt;
         default:  opB = rawB;
      endcase
   end

endmodule

//--- src/control.sv
// Opcode decoder; maps instr[15:11] onto the ALU, operand and write-back controls.
`timescale 1ns/1ps

module control (
   input  isaPkg::opcodeT opcode,
   output isaPkg::aluOpT  aluOp,
   output logic [1:0]     regSrc,
   output logic [1:0]     bSel,
   output logic [1:0]     regDst,
   output logic           regWrite,
   output logic           zeroExt,
   output logic           shift,
   output logic           subtract,
   output logic           invA,
   output logic           invB,
   output logic           slbi,
   output logic           btr,
   output logic           halt
);
   import isaPkg::*;

   always_comb begin
      aluOp    = aluAdd;
      regSrc   = srcAlu;
      bSel     = bSelReg;
      regDst   = dstRd;
      regWrite = 1'b0;
      zeroExt  = 1'b0;
      shift    = 1'b0;
      subtract = 1'b0;
      invA     = 1'b0;
      invB     = 1'b0;
      slbi     = 1'b0;
      btr      = 1'b0;
      halt     = 1'b0;
      case (opcode)
         HALT: halt = 1'b1;
         ADDI, SUBI, XORI, ANDNI, ROLI, SLLI, RORI, SRLI: begin
            bSel     = bSelImm5;
            regDst   = dstIRd;
            regWrite = 1'b1;
            zeroExt  = (opcode == XORI) || (opcode == ANDNI);
            invA     = (opcode == SUBI);   // SUBI is imm - Rs.
            subtract = (opcode == SUBI);
            invB     = (opcode == ANDNI);
            case (opcode)
               XORI:    aluOp = aluXor;
               ANDNI:   aluOp = aluAndn;
               ROLI:    aluOp = aluRol;
               SLLI:    aluOp = aluSll;
               RORI:    aluOp = aluRor;
               SRLI:    aluOp = aluSrl;
               default: aluOp = aluAdd;
            endcase
         end
         SLBI, LBI: begin
            bSel     = bSelImm8;
            regDst   = dstRs;
            regWrite = 1'b1;
            if (opcode == SLBI) begin
               aluOp   = aluSlbi;
               zeroExt = 1'b1;
               slbi    = 1'b1;
            end else begin
               aluOp  = aluPass;
               regSrc = srcImm;   // Sign-extended imm8 straight to Rs.
            end
         end
         BTR, ALUSHIFT, ALUARITH: begin
            regWrite = 1'b1;
            case (opcode)
               ALUSHIFT: aluOp = aluRegShift;
               ALUARITH: aluOp = aluRegArith;
               default: begin
                  aluOp = aluPass;
                  btr   = 1'b1;
               end
            endcase
         end
         SEQ, SLT, SLE, SCO: begin
            regWrite = 1'b1;
            shift    = 1'b1;   // Set-on-compare result.
            aluOp    = (opcode == SEQ) ? aluXor : aluAdd;
            subtract = (opcode == SLT) || (opcode == SLE);
            invB     = (opcode == SLT);   // Rs - Rt.
            invA     = (opcode == SLE);   // Rt - Rs.
         end
         default: ;   // Memory, branch, jump and NOP retire with no write.
      endcase
   end

endmodule

//--- src/isaPkg.sv
// Widths, control field encodings and enums of the 16-bit slice; every RTL file imports this.
package isaPkg;

   localparam int dataWidth   = 16;
   localparam int regIdxWidth = 3;

   // Operand B source.
   localparam logic [1:0] bSelReg  = 2'b00;
   localparam logic [1:0] bSelImm5 = 2'b01;
   localparam logic [1:0] bSelImm8 = 2'b10;

   // Destination register field.
   localparam logic [1:0] dstRd  = 2'b00;   // R-format Rd, bits 4:2.
   localparam logic [1:0] dstIRd = 2'b01;   // I-format Rd, bits 7:5.
   localparam logic [1:0] dstRs  = 2'b10;   // Rs, bits 10:8.
   localparam logic [1:0] dstR7  = 2'b11;

   // Write data source.
   localparam logic [1:0] srcAlu = 2'b10;
   localparam logic [1:0] srcImm = 2'b11;

   typedef enum logic [4:0] {
      HALT     = 5'b00000,
      NOP      = 5'b00001,
      J        = 5'b00100,
      JR       = 5'b00101,
      JAL      = 5'b00110,
      JALR     = 5'b00111,
      ADDI     = 5'b01000,
      SUBI     = 5'b01001,
      XORI     = 5'b01010,
      ANDNI    = 5'b01011,
      BEQZ     = 5'b01100,
      BNEZ     = 5'b01101,
      BLTZ     = 5'b01110,
      BGEZ     = 5'b01111,
      ST       = 5'b10000,
      LD       = 5'b10001,
      SLBI     = 5'b10010,
      STU      = 5'b10011,
      ROLI     = 5'b10100,
      SLLI     = 5'b10101,
      RORI     = 5'b10110,
      SRLI     = 5'b10111,
      LBI      = 5'b11000,
      BTR      = 5'b11001,
      ALUSHIFT = 5'b11010,
      ALUARITH = 5'b11011,
      SEQ      = 5'b11100,
      SLT      = 5'b11101,
      SLE      = 5'b11110,
      SCO      = 5'b11111
   } opcodeT;

   typedef enum logic [3:0] {
      aluRol      = 4'b0000,
      aluRegShift = 4'b0001,   // Shift kind comes from func.
      aluSll      = 4'b0010,
      aluRor      = 4'b0100,
      aluSrl      = 4'b0110,
      aluAdd      = 4'b1000,
      aluRegArith = 4'b1001,   // Arithmetic kind comes from func.
      aluSlbi     = 4'b1010,
      aluXor      = 4'b1100,
      aluAndn     = 4'b1110,
      aluPass     = 4'b1111
   } aluOpT;

endpackage
